// File: files.f
hdl/cpu_types_pkg.sv
hdl/data_path_muxs_pkg.sv
hdl/alu.sv
hdl/forwarding_unit.sv
hdl/ex_mem_reg.sv
hdl/data_ram.sv
hdl/mem_wb_reg.sv
hdl/execute_memory_pipe.sv
verification/clock_gen.sv
verification/execute_memory_pipe_tb.sv

// File: hdl/alu.sv
// ALU
// combinational arithmetic and logic unit of the execute stage
// drives zero, negative and signed overflow flags along with the result
`timescale 1ns/1ns

module alu import cpu_types_pkg::*; (
	input  aluop_t op,
	input  word_t  a,
	input  word_t  b,
	output word_t  result,
	output logic   zero,
	output logic   negative,
	output logic   overflow
);

	// shift amount is the low five bits of b
	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		// defaults, no overflow for logic ops
		result   = '0;
		overflow = 1'b0;

		case (op)
			ALU_SLL: begin
				result = a << shamt;
			end
			ALU_SRL: begin
				result = a >> shamt;
			end
			ALU_ADD: begin
				result = a + b;
				// same operand signs but the sum flips sign
				overflow = (a[WORD_W-1] == b[WORD_W-1]) &&
					(result[WORD_W-1] != a[WORD_W-1]);
			end
			ALU_SUB: begin
				result = a - b;
				// different signs and the difference takes b's sign
				overflow = (a[WORD_W-1] != b[WORD_W-1]) &&
					(result[WORD_W-1] != a[WORD_W-1]);
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_XOR: begin
				result = a ^ b;
			end
			ALU_NOR: begin
				result = ~(a | b);
			end
			ALU_SLT: begin
				result = word_t'($signed(a) < $signed(b));
			end
			ALU_SLTU: begin
				result = word_t'(a < b);
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// flags follow the result directly
	assign zero     = (result == '0);
	assign negative = result[WORD_W-1];

endmodule

// File: hdl/cpu_types_pkg.sv
// cpu datapath types
// word and register index widths, data memory depth and the alu operation encoding
// shared by every stage of the execute/memory half of the pipeline
package cpu_types_pkg;

	// datapath width
	localparam int WORD_W = 32;

	// register file index width, 32 registers
	localparam int REG_W = 5;

	// data memory size in words
	localparam int DMEM_DEPTH = 64;

	// byte offset inside a word, dropped when indexing the ram
	localparam int BYTE_OFF = 2;

	// one data word
	typedef logic [WORD_W-1:0] word_t;

	// register index
	typedef logic [REG_W-1:0] regbits_t;

	// alu operations, encoding follows the decode stage
	typedef enum logic [3:0] {
		ALU_SLL  = 4'd0,
		ALU_SRL  = 4'd1,
		ALU_ADD  = 4'd2,
		ALU_SUB  = 4'd3,
		ALU_AND  = 4'd4,
		ALU_OR   = 4'd5,
		ALU_XOR  = 4'd6,
		ALU_NOR  = 4'd7,
		ALU_SLT  = 4'd8,
		ALU_SLTU = 4'd9
	} aluop_t;

endpackage

// File: hdl/data_path_muxs_pkg.sv
// datapath mux selects
// destination register, alu b source and operand forwarding source
package data_path_muxs_pkg;

	// write back to rd (r-type) or rt (i-type)
	typedef enum logic {
		SEL_RD = 1'b0,
		SEL_RT = 1'b1
	} reg_dest_mux_selection;

	// alu b operand comes from the register or the immediate
	typedef enum logic {
		SRC_REG = 1'b0,
		SRC_IMM = 1'b1
	} alu_src_sel;

	// where an operand is taken from
	typedef enum logic [1:0] {
		FWD_NONE   = 2'd0,
		FWD_EX_MEM = 2'd1,
		FWD_MEM_WB = 2'd2
	} fwd_sel;

endpackage

// File: hdl/data_ram.sv
// data RAM
// word addressed synchronous memory, answers each request with a one-cycle dhit
// reads are registered on the dhit edge, writes land on the same edge
`timescale 1ns/1ns

module data_ram import cpu_types_pkg::*; (
	input  logic  CLK,
	input  logic  nRST,
	input  logic  dmem_ren,
	input  logic  dmem_wen,
	input  word_t dmem_addr,
	input  word_t dmem_store,
	output logic  dhit,
	output word_t dload
);

	localparam int IDX_W = $clog2(DMEM_DEPTH);

	word_t            mem [DMEM_DEPTH];
	logic [IDX_W-1:0] idx;
	// a request that has not been answered yet
	logic             req_start;

	// drop the byte offset, wrap at the memory size
	assign idx       = dmem_addr[BYTE_OFF +: IDX_W];
	assign req_start = (dmem_ren || dmem_wen) && !dhit;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			dhit <= 1'b0;
		end else begin
			// one pulse per request, low again while the requester moves on
			dhit <= req_start;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			dload <= '0;
			for (int i = 0; i < DMEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (req_start) begin
			if (dmem_wen) begin
				mem[idx] <= dmem_store;
			end
			if (dmem_ren) begin
				dload <= mem[idx];
			end
		end
	end

	// the requester still holds its request when the hit comes back
	assert property (@(posedge CLK) disable iff (!nRST)
		dhit |-> (dmem_ren || dmem_wen));

endmodule

// File: hdl/ex_mem_reg.sv
// EX/MEM pipeline register
// latches the execute results, holds data memory requests until dhit
// and takes a bubble on a load-use hazard
`timescale 1ns/1ns

module ex_mem_reg import cpu_types_pkg::*; import data_path_muxs_pkg::*; (
	input  logic                  CLK,
	input  logic                  nRST,
	input  logic                  valid,
	input  logic                  bubble,
	input  logic                  mem_stall_req,
	input  logic                  halt_in,
	input  logic                  wen,
	input  logic                  dren,
	input  logic                  dwen,
	input  reg_dest_mux_selection reg_dest,
	input  aluop_t                alu_op,
	input  regbits_t              rt,
	input  regbits_t              rd,
	input  word_t                 result,
	input  word_t                 rdat2,
	input  logic                  dhit,
	input  logic                  halted,
	output logic                  dmem_ren,
	output logic                  dmem_wen,
	output logic                  mem_busy,
	output logic                  exm_wen,
	output logic                  exm_halt,
	output regbits_t              exm_dest,
	output word_t                 dmem_addr,
	output word_t                 dmem_store,
	output word_t                 exm_result
);

	// control state
	logic                  wen_q;
	logic                  dren_q;
	logic                  dwen_q;
	logic                  halt_q;
	reg_dest_mux_selection reg_dest_q;
	aluop_t                alu_op_q;
	// payload
	regbits_t              rt_q;
	regbits_t              rd_q;
	word_t                 result_q;
	word_t                 rdat2_q;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wen_q      <= 1'b0;
			dren_q     <= 1'b0;
			dwen_q     <= 1'b0;
			halt_q     <= 1'b0;
			reg_dest_q <= SEL_RD;
			alu_op_q   <= ALU_ADD;
			rt_q       <= '0;
			rd_q       <= '0;
			result_q   <= '0;
			rdat2_q    <= '0;
		end else if (mem_busy) begin
			// request outstanding, hold everything
		end else if (bubble || mem_stall_req || !valid) begin
			// nothing accepted this cycle, also drops enables after dhit
			wen_q  <= 1'b0;
			dren_q <= 1'b0;
			dwen_q <= 1'b0;
			halt_q <= 1'b0;
		end else begin
			wen_q      <= wen;
			dren_q     <= dren;
			dwen_q     <= dwen;
			halt_q     <= halt_in;
			reg_dest_q <= reg_dest;
			alu_op_q   <= alu_op;
			rt_q       <= rt;
			rd_q       <= rd;
			result_q   <= result;
			rdat2_q    <= rdat2;
		end
	end

	// no new memory traffic once the pipe has halted
	assign dmem_ren = dren_q && !halted;
	assign dmem_wen = dwen_q && !halted;

	// waiting on the ram
	assign mem_busy = (dmem_ren || dmem_wen) && !dhit;

	// destination from the latched select, r0 is never written
	assign exm_dest = (reg_dest_q == SEL_RT) ? rt_q : rd_q;
	assign exm_wen  = wen_q && (exm_dest != '0);
	assign exm_halt = halt_q;

	// alu result doubles as the byte address for loads and stores
	assign dmem_addr  = result_q;
	assign dmem_store = rdat2_q;
	assign exm_result = result_q;

	// decode never issues a load and a store together
	assert property (@(posedge CLK) disable iff (!nRST) !(dmem_ren && dmem_wen));

	// the ram answers every request on the following cycle
	assert property (@(posedge CLK) disable iff (!nRST) mem_busy |-> ##[1:2] !mem_busy);

	// memory addresses are always formed by an add
	assert property (@(posedge CLK) disable iff (!nRST)
		(dmem_ren || dmem_wen) |-> (alu_op_q == ALU_ADD));

endmodule

// File: hdl/execute_memory_pipe.sv
// execute/memory pipeline top
// forwarding, ALU, EX/MEM, data RAM and MEM/WB of a five-stage cpu
// raises stall while memory is busy or on a load-use hazard
`timescale 1ns/1ns

module execute_memory_pipe import cpu_types_pkg::*; import data_path_muxs_pkg::*; (
	input  logic                  CLK,
	input  logic                  nRST,
	input  regbits_t              rs,
	input  regbits_t              rt,
	input  regbits_t              rd,
	input  word_t                 rdat1,
	input  word_t                 rdat2,
	input  word_t                 imm,
	input  aluop_t                alu_op,
	input  alu_src_sel            alu_src,
	input  reg_dest_mux_selection reg_dest,
	input  logic                  wen,
	input  logic                  dren,
	input  logic                  dwen,
	input  logic                  halt_in,
	input  logic                  valid,
	output logic                  stall,
	output logic                  wb_wen,
	output regbits_t              wb_reg,
	output word_t                 wb_data,
	output logic                  halted
);

	fwd_sel   fwd_a;
	fwd_sel   fwd_b;
	logic     load_hazard;
	// forwarded operands
	word_t    op_a;
	word_t    reg_b;
	word_t    alu_b;
	word_t    alu_result;
	logic     alu_negative;
	logic     alu_overflow;
	// EX/MEM outputs
	logic     dmem_ren;
	logic     dmem_wen;
	logic     mem_busy;
	logic     exm_wen;
	logic     exm_halt;
	regbits_t exm_dest;
	word_t    dmem_addr;
	word_t    dmem_store;
	word_t    exm_result;
	// ram outputs
	logic     dhit;
	word_t    dload;

	forwarding_unit fwd_unit (
		.rs(rs), .rt(rt), .alu_src(alu_src), .is_store(dwen),
		.exm_dest(exm_dest), .exm_wen(exm_wen), .exm_dren(dmem_ren),
		.mwb_dest(wb_reg), .mwb_wen(wb_wen),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .load_hazard(load_hazard)
	);

	// operand a, youngest value first
	always_comb begin
		case (fwd_a)
			FWD_EX_MEM: op_a = exm_result;
			FWD_MEM_WB: op_a = wb_data;
			default:    op_a = rdat1;
		endcase
	end

	// register b also feeds the store data
	always_comb begin
		case (fwd_b)
			FWD_EX_MEM: reg_b = exm_result;
			FWD_MEM_WB: reg_b = wb_data;
			default:    reg_b = rdat2;
		endcase
	end

	assign alu_b = (alu_src == SRC_IMM) ? imm : reg_b;

	alu alu_i (
		.op(alu_op), .a(op_a), .b(alu_b), .result(alu_result),
		.zero(), .negative(alu_negative), .overflow(alu_overflow)
	);

	// hazard only matters for an instruction actually on offer
	assign stall = mem_busy || (load_hazard && valid);

	ex_mem_reg ex_mem (
		.CLK(CLK), .nRST(nRST), .valid(valid), .bubble(load_hazard),
		.mem_stall_req(stall), .halt_in(halt_in), .wen(wen), .dren(dren),
		.dwen(dwen), .reg_dest(reg_dest), .alu_op(alu_op), .rt(rt), .rd(rd),
		.result(alu_result), .rdat2(reg_b), .dhit(dhit), .halted(halted),
		.dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .mem_busy(mem_busy),
		.exm_wen(exm_wen), .exm_halt(exm_halt), .exm_dest(exm_dest),
		.dmem_addr(dmem_addr), .dmem_store(dmem_store), .exm_result(exm_result)
	);

	data_ram dram (
		.CLK(CLK), .nRST(nRST), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
		.dmem_addr(dmem_addr), .dmem_store(dmem_store), .dhit(dhit), .dload(dload)
	);

	mem_wb_reg mem_wb (
		.CLK(CLK), .nRST(nRST), .advance(!mem_busy), .exm_wen(exm_wen),
		.exm_dren(dmem_ren), .exm_halt(exm_halt), .exm_dest(exm_dest),
		.exm_result(exm_result), .dload(dload), .wb_wen(wb_wen), .wb_reg(wb_reg),
		.wb_data(wb_data), .halted(halted)
	);

	// an accepted address add stays in the positive, non-wrapping range
	assert property (@(posedge CLK) disable iff (!nRST)
		(valid && !stall && (dren || dwen)) |-> !alu_overflow && !alu_negative);

endmodule

// File: hdl/forwarding_unit.sv
// forwarding unit
// picks the alu operand sources from EX/MEM and MEM/WB
// and flags a load-use hazard against the load sitting in EX/MEM
`timescale 1ns/1ns

module forwarding_unit import cpu_types_pkg::*; import data_path_muxs_pkg::*; (
	input  regbits_t   rs,
	input  regbits_t   rt,
	input  alu_src_sel alu_src,
	input  logic       is_store,
	input  regbits_t   exm_dest,
	input  logic       exm_wen,
	input  logic       exm_dren,
	input  regbits_t   mwb_dest,
	input  logic       mwb_wen,
	output fwd_sel     fwd_a,
	output fwd_sel     fwd_b,
	output logic       load_hazard
);

	// producers that will really write a register, never r0
	logic exm_writes;
	logic mwb_writes;
	// rt is read for r-type ops and as store data
	logic uses_rt;

	assign exm_writes = exm_wen && (exm_dest != '0);
	assign mwb_writes = mwb_wen && (mwb_dest != '0);
	assign uses_rt    = (alu_src == SRC_REG) || is_store;

	// youngest producer wins
	always_comb begin
		fwd_a = FWD_NONE;
		if (exm_writes && (exm_dest == rs)) begin
			fwd_a = FWD_EX_MEM;
		end else if (mwb_writes && (mwb_dest == rs)) begin
			fwd_a = FWD_MEM_WB;
		end
	end

	always_comb begin
		fwd_b = FWD_NONE;
		if (exm_writes && (exm_dest == rt)) begin
			fwd_b = FWD_EX_MEM;
		end else if (mwb_writes && (mwb_dest == rt)) begin
			fwd_b = FWD_MEM_WB;
		end
	end

	// a load result is not ready until it reaches MEM/WB
	assign load_hazard = exm_dren && exm_writes &&
		((exm_dest == rs) || (uses_rt && (exm_dest == rt)));

endmodule

// File: hdl/mem_wb_reg.sv
// MEM/WB pipeline register
// picks load data or the alu result and carries the destination to write back
// halted is sticky until reset
`timescale 1ns/1ns

module mem_wb_reg import cpu_types_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  logic     advance,
	input  logic     exm_wen,
	input  logic     exm_dren,
	input  logic     exm_halt,
	input  regbits_t exm_dest,
	input  word_t    exm_result,
	input  word_t    dload,
	output logic     wb_wen,
	output regbits_t wb_reg,
	output word_t    wb_data,
	output logic     halted
);

	// loads write the ram data, everything else the alu result
	word_t wb_data_nxt;

	assign wb_data_nxt = exm_dren ? dload : exm_result;

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			wb_wen  <= 1'b0;
			wb_reg  <= '0;
			wb_data <= '0;
		end else if (advance) begin
			// nothing is written back after the halt
			wb_wen  <= exm_wen && !halted;
			wb_reg  <= exm_dest;
			wb_data <= wb_data_nxt;
		end else begin
			// memory busy, bubble
			wb_wen <= 1'b0;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			halted <= 1'b0;
		end else if (advance && exm_halt) begin
			halted <= 1'b1;
		end
	end

	// r0 writes are filtered back in EX/MEM
	assert property (@(posedge CLK) disable iff (!nRST) wb_wen |-> (wb_reg != '0));

endmodule

// File: verification/clock_gen.sv
// testbench clock and reset
// free running clock, active low reset held for a fixed number of cycles
`timescale 1ns/1ns

module clock_gen #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 10
) (
	output logic CLK,
	output logic nRST
);

	initial begin
		CLK = 1'b0;
		forever begin
			#(PERIOD_NS / 2) CLK = ~CLK;
		end
	end

	// reset released just after a rising edge
	initial begin
		nRST = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1 nRST = 1'b1;
	end

endmodule

// File: verification/execute_memory_pipe_tb.sv
// execute/memory pipeline testbench
// stands in for decode and the register file, drives random ALU, load and store
// instructions and a final halt, and checks write-backs, stalls and halt against
// an in-order model
`timescale 1ns/1ns

module execute_memory_pipe_tb import cpu_types_pkg::*; import data_path_muxs_pkg::*; ();

	localparam int PERIOD_NS    = 100;
	localparam int RESET_CYCLES = 10;
	localparam int DRIVE_DELAY  = 10;
	localparam int N_RANDOM     = 250;
	localparam int N_AFTER_HALT = 4;
	// worst case budget, 4 cycles per instruction
	localparam int MAX_INSTR    = 300;
	localparam int TIMEOUT_NS   = (RESET_CYCLES + 20 + MAX_INSTR * 4) * PERIOD_NS;

	logic                  CLK;
	logic                  nRST;
	regbits_t              rs;
	regbits_t              rt;
	regbits_t              rd;
	word_t                 rdat1;
	word_t                 rdat2;
	word_t                 imm;
	aluop_t                alu_op;
	alu_src_sel            alu_src;
	reg_dest_mux_selection reg_dest;
	logic                  wen;
	logic                  dren;
	logic                  dwen;
	logic                  halt_in;
	logic                  valid;
	logic                  stall;
	logic                  wb_wen;
	regbits_t              wb_reg;
	word_t                 wb_data;
	logic                  halted;

	// register file seen by the DUT, written only from write-back
	word_t    rf [32];
	// model state
	word_t    mrf [32];
	word_t    mmem [DMEM_DEPTH];
	regbits_t exp_reg [$];
	word_t    exp_data [$];
	string    exp_name [$];
	int       exp_waits;
	logic     prev_mem;
	regbits_t prev_load_dest;
	regbits_t last_dest1;
	regbits_t last_dest2;
	// halt tracking and stats
	logic     halt_issued;
	int       halt_cycles;
	int       issued;
	int       stall_total;
	int       wb_count;
	word_t    rng;

	clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clk_rst (
		.CLK(CLK), .nRST(nRST)
	);

	execute_memory_pipe UUT (
		.CLK(CLK), .nRST(nRST), .rs(rs), .rt(rt), .rd(rd), .rdat1(rdat1), .rdat2(rdat2),
		.imm(imm), .alu_op(alu_op), .alu_src(alu_src), .reg_dest(reg_dest), .wen(wen),
		.dren(dren), .dwen(dwen), .halt_in(halt_in), .valid(valid), .stall(stall),
		.wb_wen(wb_wen), .wb_reg(wb_reg), .wb_data(wb_data), .halted(halted)
	);

	task automatic check_value(input string name, input word_t expected, input word_t actual);
		assert (expected == actual) else begin
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("Error: %s", what);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// xorshift32
	function automatic word_t next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// reference ALU written from the operation definitions
	function automatic word_t alu_model(input aluop_t op, input word_t a, input word_t b);
		case (op)
			ALU_SLL:  return a << b[4:0];
			ALU_SRL:  return a >> b[4:0];
			ALU_ADD:  return a + b;
			ALU_SUB:  return a + ~b + 32'd1;
			ALU_AND:  return a & b;
			ALU_OR:   return a | b;
			ALU_XOR:  return a ^ b;
			ALU_NOR:  return ~a & ~b;
			// signs differ, the negative one is less
			ALU_SLT:  return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
			ALU_SLTU: return word_t'(a < b);
			default:  return '0;
		endcase
	endfunction

	// register written by one of the last two instructions
	function automatic logic depends_on_recent(input regbits_t r);
		return (r != '0) && ((r == last_dest1) || (r == last_dest2));
	endfunction

	// loads and stores use r0 plus an aligned offset, 0 to 252
	task automatic pick_random_instr();
		word_t r;
		word_t s;
		r = next_random();
		s = next_random();
		rs       = {2'b00, r[2:0]};
		rt       = {2'b00, r[5:3]};
		rd       = {2'b00, r[8:6]};
		imm      = {{16{s[15]}}, s[15:0]};
		halt_in  = 1'b0;
		wen      = 1'b1;
		dren     = 1'b0;
		dwen     = 1'b0;
		alu_op   = ALU_ADD;
		alu_src  = SRC_IMM;
		reg_dest = SEL_RT;
		case (r[11:9])
			3'd0, 3'd1: begin
				rs   = '0;
				imm  = {24'd0, s[21:16], 2'b00};
				dren = 1'b1;
			end
			3'd2: begin
				rs   = '0;
				imm  = {24'd0, s[21:16], 2'b00};
				wen  = 1'b0;
				dwen = 1'b1;
			end
			default: begin
				alu_op = aluop_t'(s[31:16] % 10);
				// r-type half the time
				if (r[12]) begin
					alu_src  = SRC_REG;
					reg_dest = SEL_RD;
				end
			end
		endcase
	endtask

	task automatic pick_halt();
		rs       = '0;
		rt       = '0;
		rd       = '0;
		imm      = '0;
		alu_op   = ALU_ADD;
		alu_src  = SRC_REG;
		reg_dest = SEL_RD;
		wen      = 1'b0;
		dren     = 1'b0;
		dwen     = 1'b0;
		halt_in  = 1'b1;
	endtask

	// in-order step: expected stalls, then registers, memory and write-back queue
	task automatic run_model();
		word_t    a;
		word_t    b;
		word_t    value;
		regbits_t dest;
		logic     reads_rt;
		logic     write;
		logic     fwd_dep;
		reads_rt  = (alu_src == SRC_REG) || dwen;
		exp_waits = int'(prev_mem);
		if ((prev_load_dest != '0) && ((rs == prev_load_dest) ||
			(reads_rt && (rt == prev_load_dest)))) begin
			exp_waits++;
		end
		fwd_dep = depends_on_recent(rs) || (reads_rt && depends_on_recent(rt));
		a       = mrf[rs];
		b       = (alu_src == SRC_IMM) ? imm : mrf[rt];
		value   = alu_model(alu_op, a, b);
		dest    = (reg_dest == SEL_RT) ? rt : rd;
		write   = wen && (dest != '0) && !halt_issued;
		if (dwen && !halt_issued) begin
			mmem[value[7:2]] = mrf[rt];
		end
		if (dren) begin
			value = mmem[value[7:2]];
		end
		if (write) begin
			mrf[dest] = value;
			exp_reg.push_back(dest);
			exp_data.push_back(value);
			if (dren) begin
				exp_name.push_back("load_data");
			end else if (fwd_dep) begin
				exp_name.push_back("forwarding");
			end else begin
				exp_name.push_back("alu_result");
			end
		end
		prev_mem       = dren || dwen;
		prev_load_dest = (dren && write) ? dest : '0;
		last_dest2     = last_dest1;
		last_dest1     = write ? dest : '0;
	endtask

	// offer the instruction until accepted, register reads follow the file
	task automatic issue_instr();
		int waits;
		waits = 0;
		rdat1 = rf[rs];
		rdat2 = rf[rt];
		valid = 1'b1;
		@(negedge CLK);
		while (stall) begin
			waits++;
			@(posedge CLK);
			#DRIVE_DELAY;
			rdat1 = rf[rs];
			rdat2 = rf[rt];
			@(negedge CLK);
		end
		check_value("stall_cycles", exp_waits, waits);
		stall_total += waits;
		@(posedge CLK);
		#DRIVE_DELAY;
		issued++;
	endtask

	// write-back monitor, mid cycle
	always @(negedge CLK) begin
		if (nRST) begin
			if (halt_issued) begin
				halt_cycles++;
			end
			// halt reaches MEM/WB one edge after it is taken, then stays
			check_value("halted", word_t'(halt_cycles >= 2), halted);
			if (wb_wen) begin
				check_true(!halted, "a write-back appeared after the pipeline halted");
				check_true(exp_reg.size() > 0, "a write-back appeared that the model did not expect");
				check_value({exp_name[0], "_dest"}, exp_reg[0], wb_reg);
				check_value(exp_name[0], exp_data[0], wb_data);
				void'(exp_reg.pop_front());
				void'(exp_data.pop_front());
				void'(exp_name.pop_front());
				rf[wb_reg] = wb_data;
				wb_count++;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Error: timeout after %0d ns, the pipeline stopped taking instructions",
			TIMEOUT_NS);
		$display("Verification failed");
		$fatal(1);
	end

	initial begin
		rs             = '0;
		rt             = '0;
		rd             = '0;
		rdat1          = '0;
		rdat2          = '0;
		imm            = '0;
		alu_op         = ALU_ADD;
		alu_src        = SRC_REG;
		reg_dest       = SEL_RD;
		wen            = 1'b0;
		dren           = 1'b0;
		dwen           = 1'b0;
		halt_in        = 1'b0;
		valid          = 1'b0;
		rng            = 32'd33;
		prev_mem       = 1'b0;
		prev_load_dest = '0;
		last_dest1     = '0;
		last_dest2     = '0;
		halt_issued    = 1'b0;
		halt_cycles    = 0;
		issued         = 0;
		stall_total    = 0;
		wb_count       = 0;
		for (int i = 0; i < 32; i++) begin
			rf[i]  = '0;
			mrf[i] = '0;
		end
		for (int i = 0; i < DMEM_DEPTH; i++) begin
			mmem[i] = '0;
		end

		// outputs quiet once reset is released
		@(posedge nRST);
		@(negedge CLK);
		check_value("reset_stall", 0, stall);
		check_value("reset_wb_wen", 0, wb_wen);
		check_value("reset_wb_reg", 0, wb_reg);
		check_value("reset_wb_data", 0, wb_data);
		check_value("reset_halted", 0, halted);
		@(posedge CLK);
		#DRIVE_DELAY;

		for (int n = 0; n < N_RANDOM; n++) begin
			pick_random_instr();
			run_model();
			issue_instr();
		end
		pick_halt();
		run_model();
		issue_instr();
		halt_issued = 1'b1;

		// ALU ops behind the halt must not write back
		for (int n = 0; n < N_AFTER_HALT; n++) begin
			pick_random_instr();
			dren = 1'b0;
			dwen = 1'b0;
			wen  = 1'b1;
			run_model();
			issue_instr();
		end
		valid = 1'b0;
		repeat (4) @(negedge CLK);
		check_value("pending_writebacks", 0, exp_reg.size());

		$display("%0d instructions, %0d write-backs, %0d stall cycles",
			issued, wb_count, stall_total);
		$display("Verification passed");
		$finish;
	end

endmodule
